// File: hw/periph_cfg_pkg.sv
package periph_cfg_pkg;

  // Crossbar size: four cores plus the master peripheral port
  localparam int unsigned N_MASTERS = 5;
  localparam int unsigned N_SLAVES  = 4;

  localparam int unsigned MASTER_IDX_W = $clog2(N_MASTERS);
  localparam int unsigned SLAVE_IDX_W  = $clog2(N_SLAVES);

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = 4;

  // Cluster window, compared against addr[31:24]
  localparam logic [7:0] CLUSTER_BASE = 8'h10;

  // Peripheral range inside the cluster, compared against addr[23:20]
  localparam logic [3:0] PERIPH_WIN_LO = 4'h2;
  localparam logic [3:0] PERIPH_WIN_HI = 4'h3;

  // Slave index field starts here
  localparam int unsigned ROUTE_LSB = 16;

  // Everything outside the peripheral window lands here
  localparam int unsigned EXT_SLAVE = 3;

endpackage

// File: hw/periph_bus_pkg.sv
package periph_bus_pkg;

  import periph_cfg_pkg::*;

  typedef logic [SLAVE_IDX_W-1:0] slave_idx_t;
  typedef logic [N_MASTERS-1:0]   master_id_t;
  typedef master_id_t [N_MASTERS-1:0] master_id_tbl_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    master_id_t        id;
    // Low for a write
    logic              we_n;
    logic [BE_W-1:0]   be;
  } periph_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    master_id_t        id;
    // Error flag from the slave
    logic              opc;
  } periph_resp_t;

  function automatic master_id_tbl_t gen_master_ids();
    master_id_tbl_t ids;
    for (int i = 0; i < N_MASTERS; i++) begin
      ids[i]    = '0;
      ids[i][i] = 1'b1;
    end
    return ids;
  endfunction

  // One-hot identifier per master index
  localparam master_id_tbl_t MASTER_IDS = gen_master_ids();

endpackage

// File: hw/periph_req_demux.sv
`timescale 1ns/1ps

module periph_req_demux
  import periph_cfg_pkg::*;
  import periph_bus_pkg::*;
(
  input  logic                req_i,
  input  periph_req_t         req_data_i,
  output logic [N_SLAVES-1:0] slave_req_o,
  input  logic [N_SLAVES-1:0] slave_gnt_i,
  output logic                gnt_o
);

  logic       in_cluster;
  logic       in_periph;
  slave_idx_t target;

  assign in_cluster = (req_data_i.addr[31:24] == CLUSTER_BASE);
  assign in_periph  = (req_data_i.addr[23:20] >= PERIPH_WIN_LO) &&
                      (req_data_i.addr[23:20] <= PERIPH_WIN_HI);

  // Outside the peripheral window everything goes to the external slave
  always_comb begin
    if (in_cluster && in_periph) begin
      target = req_data_i.addr[ROUTE_LSB +: SLAVE_IDX_W];
    end else begin
      target = slave_idx_t'(EXT_SLAVE);
    end
  end

  always_comb begin
    slave_req_o         = '0;
    slave_req_o[target] = req_i;
  end

  // Only the decoded slave's grant comes back
  assign gnt_o = slave_gnt_i[target];

  // Steered request stays a single bit, and the arbiter
  // behind it never grants a master that is idle
  always_comb begin
    assert final ($onehot0(slave_req_o))
      else $error("demux drives more than one slave request");
    assert final (!gnt_o || req_i)
      else $error("grant returned to an idle master");
  end

endmodule

// File: hw/periph_rr_arbiter.sv
`timescale 1ns/1ps

module periph_rr_arbiter
  import periph_cfg_pkg::*;
  import periph_bus_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic        [N_MASTERS-1:0]  req_i,
  input  periph_req_t [N_MASTERS-1:0]  req_data_i,
  output logic        [N_MASTERS-1:0]  gnt_o,
  output logic                         slave_req_o,
  output periph_req_t                  slave_data_o,
  input  logic                         slave_gnt_i
);

  logic [MASTER_IDX_W-1:0] ptr_q;
  logic [MASTER_IDX_W-1:0] sel;
  logic                    found;
  logic                    xfer;

  // First requester at or after the pointer, wrapping around
  always_comb begin
    int unsigned cand;
    sel   = ptr_q;
    found = 1'b0;
    for (int unsigned k = 0; k < N_MASTERS; k++) begin
      cand = (int'(ptr_q) + k) % N_MASTERS;
      if (!found && req_i[cand]) begin
        found = 1'b1;
        sel   = MASTER_IDX_W'(cand);
      end
    end
  end

  assign slave_req_o  = found;
  assign slave_data_o = req_data_i[sel];

  always_comb begin
    gnt_o      = '0;
    gnt_o[sel] = found & slave_gnt_i;
  end

  assign xfer = found & slave_gnt_i;

  // Winner drops to lowest priority after a transfer
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (xfer) begin
      ptr_q <= (sel == MASTER_IDX_W'(N_MASTERS - 1)) ? '0 : sel + 1'b1;
    end
  end

  a_gnt_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_o))
    else $error("more than one master granted");

  a_gnt_to_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (gnt_o & ~req_i) == '0)
    else $error("grant to a master that is not requesting");

  // Masters hold their request, so a stalled slave keeps seeing one
  a_stall_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slave_req_o && !slave_gnt_i |=> slave_req_o)
    else $error("request withdrawn while slave stalls");

endmodule

// File: hw/periph_resp_router.sv
`timescale 1ns/1ps

module periph_resp_router
  import periph_cfg_pkg::*;
  import periph_bus_pkg::*;
(
  input  master_id_t                    id_i,
  input  logic         [N_SLAVES-1:0]   slave_rvalid_i,
  input  periph_resp_t [N_SLAVES-1:0]   slave_resp_i,
  output logic                          rvalid_o,
  output periph_resp_t                  resp_o
);

  logic [N_SLAVES-1:0] match;

  // A slave response belongs here when its identifier is ours
  for (genvar j = 0; j < N_SLAVES; j++) begin : gen_match
    assign match[j] = slave_rvalid_i[j] && (slave_resp_i[j].id == id_i);
  end

  always_comb begin
    resp_o = '0;
    for (int j = 0; j < N_SLAVES; j++) begin
      if (match[j]) begin
        resp_o = slave_resp_i[j];
      end
    end
  end

  assign rvalid_o = |match;

  // Each master has one request in flight at a time,
  // so two slaves never answer it together
  always_comb begin
    assert final ($onehot0(match))
      else $error("two slave responses for one master in a cycle");
  end

endmodule

// File: hw/periph_xbar.sv
`timescale 1ns/1ps

module periph_xbar
  import periph_cfg_pkg::*;
  import periph_bus_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic         [N_MASTERS-1:0]  m_req_i,
  input  periph_req_t  [N_MASTERS-1:0]  m_req_data_i,
  output logic         [N_MASTERS-1:0]  m_gnt_o,
  output logic         [N_MASTERS-1:0]  m_rvalid_o,
  output periph_resp_t [N_MASTERS-1:0]  m_resp_o,
  output logic         [N_SLAVES-1:0]   s_req_o,
  output periph_req_t  [N_SLAVES-1:0]   s_req_data_o,
  input  logic         [N_SLAVES-1:0]   s_gnt_i,
  input  logic         [N_SLAVES-1:0]   s_rvalid_i,
  input  periph_resp_t [N_SLAVES-1:0]   s_resp_i
);

  periph_req_t [N_MASTERS-1:0]                req_data;
  logic        [N_MASTERS-1:0][N_SLAVES-1:0]  m2s_req;
  logic        [N_MASTERS-1:0][N_SLAVES-1:0]  m2s_gnt;

  for (genvar i = 0; i < N_MASTERS; i++) begin : gen_masters
    // Identifier comes from the port index, not from the master
    assign req_data[i] = '{
      addr: m_req_data_i[i].addr,
      data: m_req_data_i[i].data,
      id:   MASTER_IDS[i],
      we_n: m_req_data_i[i].we_n,
      be:   m_req_data_i[i].be
    };

    periph_req_demux i_req_demux (
      .req_i       (m_req_i[i]),
      .req_data_i  (req_data[i]),
      .slave_req_o (m2s_req[i]),
      .slave_gnt_i (m2s_gnt[i]),
      .gnt_o       (m_gnt_o[i])
    );

    periph_resp_router i_resp_router (
      .id_i           (MASTER_IDS[i]),
      .slave_rvalid_i (s_rvalid_i),
      .slave_resp_i   (s_resp_i),
      .rvalid_o       (m_rvalid_o[i]),
      .resp_o         (m_resp_o[i])
    );
  end

  for (genvar j = 0; j < N_SLAVES; j++) begin : gen_slaves
    logic [N_MASTERS-1:0] arb_req;
    logic [N_MASTERS-1:0] arb_gnt;

    // Regroup the per-master vectors by slave
    for (genvar k = 0; k < N_MASTERS; k++) begin : gen_regroup
      assign arb_req[k]    = m2s_req[k][j];
      assign m2s_gnt[k][j] = arb_gnt[k];
    end

    periph_rr_arbiter i_arb (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_i        (arb_req),
      .req_data_i   (req_data),
      .gnt_o        (arb_gnt),
      .slave_req_o  (s_req_o[j]),
      .slave_data_o (s_req_data_o[j]),
      .slave_gnt_i  (s_gnt_i[j])
    );
  end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Synchronous release after two rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: verification/periph_xbar_tb.sv
`timescale 1ns/1ps

module periph_xbar_tb
  import periph_cfg_pkg::*;
  import periph_bus_pkg::*;
();

  localparam int RUN_CYCLES    = 1500;
  localparam int CONTEND_START = 1000;
  localparam int WAIT_LIMIT    = 200;

  logic                          clk;
  logic                          rst_n;
  logic         [N_MASTERS-1:0]  m_req;
  periph_req_t  [N_MASTERS-1:0]  m_req_data;
  logic         [N_MASTERS-1:0]  m_gnt;
  logic         [N_MASTERS-1:0]  m_rvalid;
  periph_resp_t [N_MASTERS-1:0]  m_resp;
  logic         [N_SLAVES-1:0]   s_req;
  periph_req_t  [N_SLAVES-1:0]   s_req_data;
  logic         [N_SLAVES-1:0]   s_gnt;
  logic         [N_SLAVES-1:0]   s_rvalid;
  periph_resp_t [N_SLAVES-1:0]   s_resp;

  integer               seed;
  int                   err_cnt;
  int                   check_cnt;
  int                   cycle;
  bit                   contend;
  bit                   draining;
  bit   [N_MASTERS-1:0] in_flight;
  int                   ptr_m [N_SLAVES];
  int                   waited [N_MASTERS];
  int                   pending [N_MASTERS];
  periph_req_t          pend_q [N_SLAVES][$];
  int                   due_q [N_SLAVES][$];

  tb_clock_gen clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  periph_xbar periph_xbar_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .m_req_i      (m_req),
    .m_req_data_i (m_req_data),
    .m_gnt_o      (m_gnt),
    .m_rvalid_o   (m_rvalid),
    .m_resp_o     (m_resp),
    .s_req_o      (s_req),
    .s_req_data_o (s_req_data),
    .s_gnt_i      (s_gnt),
    .s_rvalid_i   (s_rvalid),
    .s_resp_i     (s_resp)
  );

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  // Cluster window 0x10, sub-window 2..3, else the external slave
  function automatic int target_slave(logic [31:0] a);
    if (a[31:24] == 8'h10 && (a[23:20] == 4'h2 || a[23:20] == 4'h3)) begin
      return int'(a[17:16]);
    end
    return 3;
  endfunction

  function automatic logic [31:0] slave_rdata(logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c;
  endfunction

  task automatic new_addr(output logic [31:0] a);
    int kind;
    int win;
    a    = $random(seed);
    kind = {$random(seed)} % 3;
    win  = {$random(seed)} % 14;
    if (contend) begin
      // All masters on slave 1
      a[31:16] = 16'h1021;
    end else if (kind == 0) begin
      a[31:24] = 8'h10;
      a[23:20] = {3'b001, a[0]};
    end else if (kind == 1) begin
      a[31:24] = 8'h10;
      a[23:20] = (win < 2) ? 4'(win) : 4'(win + 2);
    end
  endtask

  task automatic drive_cycle();
    logic [31:0] a;
    periph_req_t nreq;
    periph_req_t head;
    for (int i = 0; i < N_MASTERS; i++) begin
      if (in_flight[i]) begin
        m_req[i] <= 1'b0;
      end else if (!m_req[i] && !draining && (contend || {$random(seed)} % 4 == 0)) begin
        new_addr(a);
        nreq.addr = a;
        nreq.data = $random(seed);
        nreq.id   = master_id_t'($random(seed));
        nreq.we_n = 1'($random(seed));
        nreq.be   = 4'($random(seed));
        m_req[i]      <= 1'b1;
        m_req_data[i] <= nreq;
      end
    end
    for (int j = 0; j < N_SLAVES; j++) begin
      s_gnt[j] <= ({$random(seed)} % 3 != 0);
      if (pend_q[j].size() > 0 && due_q[j][0] <= cycle) begin
        head = pend_q[j].pop_front();
        void'(due_q[j].pop_front());
        s_rvalid[j] <= 1'b1;
        s_resp[j]   <= '{data: slave_rdata(head.addr), id: head.id, opc: ^head.addr};
      end else begin
        s_rvalid[j] <= 1'b0;
      end
    end
  endtask

  task automatic check_cycle();
    int                   tgt [N_MASTERS];
    int                   choice;
    int                   k;
    periph_req_t          exp_req;
    logic [N_MASTERS-1:0] gnt_exp;
    logic [N_MASTERS-1:0] rv_exp;
    gnt_exp = '0;
    rv_exp  = '0;
    for (int i = 0; i < N_MASTERS; i++) begin
      tgt[i] = target_slave(m_req_data[i].addr);
    end
    for (int j = 0; j < N_SLAVES; j++) begin
      choice = -1;
      for (int n = 0; n < N_MASTERS; n++) begin
        k = (ptr_m[j] + n) % N_MASTERS;
        if (choice < 0 && m_req[k] && tgt[k] == j) begin
          choice = k;
        end
      end
      compare($sformatf("slave %0d req", j), 64'(choice >= 0), 64'(s_req[j]));
      if (choice >= 0) begin
        exp_req    = m_req_data[choice];
        exp_req.id = master_id_t'(1 << choice);
        compare($sformatf("slave %0d addr", j), 64'(exp_req.addr), 64'(s_req_data[j].addr));
        compare($sformatf("slave %0d data", j), 64'(exp_req.data), 64'(s_req_data[j].data));
        compare($sformatf("slave %0d be", j), 64'(exp_req.be), 64'(s_req_data[j].be));
        compare($sformatf("slave %0d we_n", j), 64'(exp_req.we_n), 64'(s_req_data[j].we_n));
        compare($sformatf("slave %0d id", j), 64'(exp_req.id), 64'(s_req_data[j].id));
        if (s_gnt[j]) begin
          gnt_exp[choice] = 1'b1;
          in_flight[choice] = 1'b1;
          pend_q[j].push_back(exp_req);
          due_q[j].push_back(cycle + 1 + {$random(seed)} % 3);
          ptr_m[j] = (choice + 1) % N_MASTERS;
        end
      end
    end
    compare("master grants", 64'(gnt_exp), 64'(m_gnt));
    // Losers at a slave count one more transfer ahead of them, taken from the DUT's grants
    for (int j = 0; j < N_SLAVES; j++) begin
      if (s_req[j] && s_gnt[j]) begin
        for (int i = 0; i < N_MASTERS; i++) begin
          if (m_req[i] && tgt[i] == j) begin
            if (m_gnt[i]) begin
              waited[i] = 0;
            end else begin
              waited[i]++;
              if (waited[i] == N_MASTERS) begin
                err_cnt++;
                $display("Master %0d passed over for %0d transfers at slave %0d",
                         i, waited[i], j);
              end
            end
          end
        end
      end
    end
    for (int j = 0; j < N_SLAVES; j++) begin
      for (int i = 0; i < N_MASTERS; i++) begin
        if (s_rvalid[j] && s_resp[j].id == master_id_t'(1 << i)) begin
          rv_exp[i] = 1'b1;
          in_flight[i] = 1'b0;
          pending[i] = 0;
          compare($sformatf("master %0d rdata", i), 64'(s_resp[j].data), 64'(m_resp[i].data));
          compare($sformatf("master %0d opc", i), 64'(s_resp[j].opc), 64'(m_resp[i].opc));
          compare($sformatf("master %0d rid", i), 64'(master_id_t'(1 << i)),
                  64'(m_resp[i].id));
        end
      end
    end
    compare("master rvalid", 64'(rv_exp), 64'(m_rvalid));
    for (int i = 0; i < N_MASTERS; i++) begin
      if (m_req[i] || in_flight[i]) begin
        pending[i]++;
        if (pending[i] == WAIT_LIMIT) begin
          err_cnt++;
          $display("Master %0d got no response within %0d cycles", i, WAIT_LIMIT);
        end
      end
    end
  endtask

  initial begin
    int n;
    seed       = 89;
    err_cnt    = 0;
    check_cnt  = 0;
    cycle      = 0;
    contend    = 1'b0;
    draining   = 1'b0;
    in_flight  = '0;
    m_req      = '0;
    m_req_data = '0;
    s_gnt      = '0;
    s_rvalid   = '0;
    s_resp     = '0;
    for (int j = 0; j < N_SLAVES; j++) begin
      ptr_m[j] = 0;
    end
    for (int i = 0; i < N_MASTERS; i++) begin
      waited[i]  = 0;
      pending[i] = 0;
    end
    // Let time-zero initialization settle
    #1;
    n = 0;
    while (rst_n !== 1'b1 && n < 20) begin
      @(negedge clk);
      compare("slave requests in reset", 64'(0), 64'(s_req));
      n++;
    end
    if (rst_n !== 1'b1) begin
      err_cnt++;
      $display("Reset was never released");
    end
    for (cycle = 0; cycle < RUN_CYCLES; cycle++) begin
      contend = (cycle >= CONTEND_START);
      @(posedge clk);
      drive_cycle();
      @(negedge clk);
      check_cycle();
    end
    // Stop issuing and let outstanding traffic finish
    draining = 1'b1;
    n = 0;
    while ((m_req != '0 || in_flight != '0) && n < WAIT_LIMIT) begin
      @(posedge clk);
      drive_cycle();
      @(negedge clk);
      check_cycle();
      cycle++;
      n++;
    end
    if (m_req != '0 || in_flight != '0) begin
      err_cnt++;
      $display("Outstanding requests did not drain within %0d cycles", WAIT_LIMIT);
    end
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: periph_xbar.f
hw/periph_cfg_pkg.sv
hw/periph_bus_pkg.sv
hw/periph_req_demux.sv
hw/periph_rr_arbiter.sv
hw/periph_resp_router.sv
hw/periph_xbar.sv
verification/tb_clock_gen.sv
verification/periph_xbar_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the crossbar testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module periph_xbar_tb \
  -f periph_xbar.f \
  --Mdir build \
  -o periph_xbar_sim

./build/periph_xbar_sim | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0
